//--- sim/rv_core_patterns.txt
// columns: instruction word, expected rd index, expected rd data (all hex)
// rd index 00 means no register write at retire, the data column is then unused
800000B7 01 80000000 // lui   x1, 0x80000
FFF00113 02 FFFFFFFF // addi  x2, x0, -1
7FF00193 03 000007FF // addi  x3, x0, 2047
12345217 04 1234500C // auipc x4, 0x12345
002082B3 05 7FFFFFFF // add   x5, x1, x2
40118333 06 800007FF // sub   x6, x3, x1
0030A3B3 07 00000001 // slt   x7, x1, x3
0030B433 08 00000000 // sltu  x8, x1, x3
002194B3 09 80000000 // sll   x9, x3, x2
40435533 0A FFF80000 // sra   x10, x6, x4
004355B3 0B 00080000 // srl   x11, x6, x4
0062C633 0C FFFFF800 // xor   x12, x5, x6
0030E6B3 0D 800007FF // or    x13, x1, x3
00417733 0E 1234500C // and   x14, x2, x4
FFF12793 0F 00000000 // slti  x15, x2, -1
FFF1B813 10 00000001 // sltiu x16, x3, -1
8001C893 11 FFFFFFFF // xori  x17, x3, -2048
FF00E913 12 FFFFFFF0 // ori   x18, x1, -16
F0027993 13 12345000 // andi  x19, x4, -256
00411A13 14 FFFFFFF0 // slli  x20, x2, 4
01F0DA93 15 00000001 // srli  x21, x1, 31
4040DB13 16 F8000000 // srai  x22, x1, 4
06400193 03 00000064 // addi  x3, x0, 100, new value for x3
00208033 00 00000000 // add   x0, x1, x2
00000F8B 00 00000000 // unknown opcode
41618C33 18 08000064 // sub   x24, x3, x22, reads x3 three slots later
00000073 00 00000000 // ecall
00000013 00 00000000 // nop
01804CB3 19 08000064 // xor   x25, x0, x24, reads x24 three slots later
00100073 00 00000000 // ebreak

//--- rv_core.f
+incdir+include
logic/rv_isa_pkg.sv
logic/rv_pipe_pkg.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_core.sv
sim/tb_rv_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_rv_core
FILELIST  ?= rv_core.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_rv_core.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module tb_rv_core;
    import rv_isa_pkg::*;

    // ========================================
    // limits and storage
    // ========================================

    localparam int    MAX_ROWS       = 64;
    localparam int    RESET_CYCLES   = 5;
    localparam int    FILL_CYCLES    = 4;
    localparam int    FILL_TIMEOUT   = 20;
    localparam int    RETIRE_TIMEOUT = 8;
    // addi x0, x0, 0 is returned for any address outside the program
    localparam inst_t NOP_WORD       = 32'h0000_0013;

    logic      clk;
    logic      rst;
    word_t     imem_raddr;
    inst_t     imem_rdata;
    logic      retire_valid;
    inst_t     retire_inst;
    logic      retire_halt;
    word_t     retire_pc;
    reg_addr_t retire_rd_waddr;
    word_t     retire_rd_wdata;

    // three words per row: instruction, expected rd index, expected rd data
    logic [31:0] pattern_words [0:3*MAX_ROWS-1];
    int          row_count;
    int          test_count;
    int          failed_tests;
    int          check_errors;
    logic        timed_out;

    rv_core DUT (
        .i_clk             (clk),
        .i_rst             (rst),
        .o_imem_raddr      (imem_raddr),
        .i_imem_rdata      (imem_rdata),
        .o_retire_valid    (retire_valid),
        .o_retire_inst     (retire_inst),
        .o_retire_halt     (retire_halt),
        .o_retire_pc       (retire_pc),
        .o_retire_rd_waddr (retire_rd_waddr),
        .o_retire_rd_wdata (retire_rd_wdata)
    );

    always #10 clk = ~clk;

    // instruction memory answers in the same cycle, one pattern row per word
    always_comb begin
        int index;
        index = int'((imem_raddr - `RV_RESET_ADDR) >> 2);
        if ($isunknown(imem_raddr) || (index >= row_count)) begin
            imem_rdata = NOP_WORD;
        end else begin
            imem_rdata = pattern_words[3*index];
        end
    end

    // ========================================
    // compare tasks
    // ========================================

    task automatic compare_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            check_errors++;
        end
    endtask

    task automatic compare_addr(input string name, input reg_addr_t actual,
                                input reg_addr_t expected);
        if (actual !== expected) begin
            $display("error at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
            check_errors++;
        end
    endtask

    task automatic compare_inst(input string name, input inst_t actual, input inst_t expected);
        if (actual !== expected) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            check_errors++;
        end
    endtask

    task automatic compare_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
            check_errors++;
        end
    endtask

    // ========================================
    // sequencing
    // ========================================

    // the program ends with the first ebreak row, rows after it are ignored
    task automatic load_patterns();
        row_count = 0;
        $readmemh("sim/rv_core_patterns.txt", pattern_words);
        for (int i = 0; i < MAX_ROWS; i++) begin
            if ((row_count == 0) && (pattern_words[3*i] === EBREAK_WORD)) begin
                row_count = i + 1;
            end
        end
        if (row_count == 0) begin
            $display("the patterns file holds no ebreak row, so the program never halts");
            check_errors++;
        end
    endtask

    // outputs are sampled on the falling edge, half a cycle after they change
    task automatic wait_retire(input int limit, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!retire_valid && (cycles < limit));
        if (!retire_valid) begin
            timed_out = 1'b1;
        end
    endtask

    task automatic report_test(input string label, input int errors_before);
        test_count++;
        if (timed_out || (check_errors != errors_before)) begin
            failed_tests++;
            $display("test %0d %s: mismatch", test_count, label);
        end else begin
            $display("test %0d %s: ok", test_count, label);
        end
    endtask

    // the last falling edge seen is the first one with a retire, so one less were empty
    task automatic check_fill();
        int cycles;
        int errors_before;
        errors_before = check_errors;
        wait_retire(FILL_TIMEOUT, cycles);
        if (timed_out) begin
            $display("no instruction retired within %0d cycles after reset", FILL_TIMEOUT);
        end else if ((cycles - 1) != FILL_CYCLES) begin
            $display("retire valid was low for %0d cycles after reset instead of %0d",
                     cycles - 1, FILL_CYCLES);
            check_errors++;
        end
        report_test("pipeline fill", errors_before);
    endtask

    task automatic check_row(input int row, input word_t expected_pc);
        inst_t     inst;
        reg_addr_t rd_addr;
        word_t     rd_data;
        int        errors_before;
        inst          = pattern_words[3*row];
        rd_addr       = reg_addr_t'(pattern_words[3*row+1]);
        rd_data       = pattern_words[3*row+2];
        errors_before = check_errors;
        compare_inst("o_retire_inst", retire_inst, inst);
        compare_word("o_retire_pc", retire_pc, expected_pc);
        // fetch moves one word per cycle, so it runs four words ahead of retire
        compare_word("o_imem_raddr", imem_raddr, expected_pc + word_t'(4 * FILL_CYCLES));
        // only the final row of the program, its ebreak, may raise halt
        compare_bit("o_retire_halt", retire_halt, row == (row_count - 1));
        compare_addr("o_retire_rd_waddr", retire_rd_waddr, rd_addr);
        // write data has no meaning unless a register is written
        if (rd_addr != '0) begin
            compare_word("o_retire_rd_wdata", retire_rd_wdata, rd_data);
        end
        report_test($sformatf("row %0d pc %h inst %h", row, expected_pc, inst), errors_before);
    endtask

    initial begin
        int    cycles;
        word_t expected_pc;
        clk          = 1'b0;
        rst          = 1'b1;
        row_count    = 0;
        test_count   = 0;
        failed_tests = 0;
        check_errors = 0;
        timed_out    = 1'b0;
        load_patterns();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        check_fill();
        // consecutive rows retire in consecutive cycles from consecutive words
        expected_pc = `RV_RESET_ADDR;
        for (int row = 0; (row < row_count) && !timed_out; row++) begin
            if (row > 0) begin
                wait_retire(RETIRE_TIMEOUT, cycles);
                if (timed_out) begin
                    $display("row %0d did not retire within %0d cycles", row, RETIRE_TIMEOUT);
                end
            end
            if (!timed_out) begin
                check_row(row, expected_pc);
            end
            expected_pc = expected_pc + word_t'(4);
        end
        $display("%0d tests run, %0d failed, %0d checks failed",
                 test_count, failed_tests, check_errors);
        if ((check_errors == 0) && !timed_out && (row_count > 0)) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- logic/rv_core.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_core (
    input  logic                  i_clk,
    input  logic                  i_rst,
    output rv_isa_pkg::word_t     o_imem_raddr,
    input  rv_isa_pkg::inst_t     i_imem_rdata,
    output logic                  o_retire_valid,
    output rv_isa_pkg::inst_t     o_retire_inst,
    output logic                  o_retire_halt,
    output rv_isa_pkg::word_t     o_retire_pc,
    output rv_isa_pkg::reg_addr_t o_retire_rd_waddr,
    output rv_isa_pkg::word_t     o_retire_rd_wdata
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    word_t     pc;
    // one valid bit per stage register, the only reset state of the pipe
    logic      if_id_valid, id_ex_valid, ex_mem_valid, mem_wb_valid;
    word_t     if_id_pc, id_ex_pc, ex_mem_pc, mem_wb_pc;
    inst_t     if_id_inst, id_ex_inst, ex_mem_inst, mem_wb_inst;
    reg_addr_t id_ex_rd_addr, ex_mem_rd_addr, mem_wb_rd_addr;
    logic      id_ex_rd_wen, ex_mem_rd_wen, mem_wb_rd_wen;
    logic      id_ex_halt, ex_mem_halt, mem_wb_halt;
    word_t     id_ex_rs1_data, id_ex_rs2_data, id_ex_imm;
    alu_op_e   id_ex_alu_op;
    op_a_sel_e id_ex_op_a_sel;
    op_b_sel_e id_ex_op_b_sel;
    word_t     ex_mem_alu_result, mem_wb_alu_result;
    // decode stage outputs
    reg_addr_t dec_rs1_addr, dec_rs2_addr, dec_rd_addr;
    word_t     dec_imm, rs1_data, rs2_data;
    alu_op_e   dec_alu_op;
    op_a_sel_e dec_op_a_sel;
    op_b_sel_e dec_op_b_sel;
    logic      dec_rd_wen, dec_halt;
    // execute and writeback nets
    word_t     alu_a, alu_b, alu_result;
    logic      wb_wen;

    // ========================================
    // fetch
    // ========================================
    // no branches exist, so the pc simply walks through memory
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc <= `RV_RESET_ADDR;
        end else begin
            pc <= pc + word_t'(4);
        end
    end

    assign o_imem_raddr = pc;

    // a fresh word enters the pipe every cycle once reset is gone
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            if_id_valid  <= 1'b0;
            id_ex_valid  <= 1'b0;
            ex_mem_valid <= 1'b0;
            mem_wb_valid <= 1'b0;
        end else begin
            if_id_valid  <= 1'b1;
            id_ex_valid  <= if_id_valid;
            ex_mem_valid <= id_ex_valid;
            mem_wb_valid <= ex_mem_valid;
        end
    end

    // ========================================
    // decode
    // ========================================
    rv_decoder u_decoder (
        .i_inst     (if_id_inst),
        .o_rs1_addr (dec_rs1_addr),
        .o_rs2_addr (dec_rs2_addr),
        .o_rd_addr  (dec_rd_addr),
        .o_imm      (dec_imm),
        .o_alu_op   (dec_alu_op),
        .o_op_a_sel (dec_op_a_sel),
        .o_op_b_sel (dec_op_b_sel),
        .o_rd_wen   (dec_rd_wen),
        .o_halt     (dec_halt)
    );

    // the writeback write reaches a decode read three slots behind it
    rv_regfile u_regfile (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_rs1_addr (dec_rs1_addr),
        .i_rs2_addr (dec_rs2_addr),
        .i_rd_addr  (mem_wb_rd_addr),
        .i_rd_wen   (wb_wen),
        .i_rd_data  (mem_wb_alu_result),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    // ========================================
    // execute
    // ========================================
    assign alu_a = (id_ex_op_a_sel == OP_A_PC) ? id_ex_pc : id_ex_rs1_data;
    assign alu_b = (id_ex_op_b_sel == OP_B_IMM) ? id_ex_imm : id_ex_rs2_data;

    rv_alu u_alu (
        .i_op     (id_ex_alu_op),
        .i_a      (alu_a),
        .i_b      (alu_b),
        .o_result (alu_result)
    );

    // stage payload moves every cycle and is qualified by the valid chain
    // the memory stage only carries the execute results one cycle further
    always_ff @(posedge i_clk) begin
        if_id_pc          <= pc;
        if_id_inst        <= i_imem_rdata;
        id_ex_pc          <= if_id_pc;
        id_ex_inst        <= if_id_inst;
        id_ex_rs1_data    <= rs1_data;
        id_ex_rs2_data    <= rs2_data;
        id_ex_imm         <= dec_imm;
        id_ex_rd_addr     <= dec_rd_addr;
        id_ex_rd_wen      <= dec_rd_wen;
        id_ex_halt        <= dec_halt;
        id_ex_alu_op      <= dec_alu_op;
        id_ex_op_a_sel    <= dec_op_a_sel;
        id_ex_op_b_sel    <= dec_op_b_sel;
        ex_mem_pc         <= id_ex_pc;
        ex_mem_inst       <= id_ex_inst;
        ex_mem_alu_result <= alu_result;
        ex_mem_rd_addr    <= id_ex_rd_addr;
        ex_mem_rd_wen     <= id_ex_rd_wen;
        ex_mem_halt       <= id_ex_halt;
        mem_wb_pc         <= ex_mem_pc;
        mem_wb_inst       <= ex_mem_inst;
        mem_wb_alu_result <= ex_mem_alu_result;
        mem_wb_rd_addr    <= ex_mem_rd_addr;
        mem_wb_rd_wen     <= ex_mem_rd_wen;
        mem_wb_halt       <= ex_mem_halt;
    end

    // ========================================
    // writeback and retire
    // ========================================
    // bubbles during fill never touch the register file
    assign wb_wen = mem_wb_valid && mem_wb_rd_wen;

    assign o_retire_valid    = mem_wb_valid;
    assign o_retire_inst     = mem_wb_inst;
    assign o_retire_halt     = mem_wb_valid && mem_wb_halt;
    assign o_retire_pc       = mem_wb_pc;
    assign o_retire_rd_waddr = wb_wen ? mem_wb_rd_addr : '0;
    assign o_retire_rd_wdata = mem_wb_alu_result;

    // back-to-back retires come from consecutive fetch addresses
    assert property (@(posedge i_clk) disable iff (i_rst)
        o_retire_valid ##1 o_retire_valid |-> o_retire_pc == $past(o_retire_pc) + word_t'(4));

endmodule

//--- logic/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
    input  rv_pipe_pkg::alu_op_e i_op,
    input  rv_isa_pkg::word_t    i_a,
    input  rv_isa_pkg::word_t    i_b,
    output rv_isa_pkg::word_t    o_result
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // only the low five bits of the second operand shift
    assign shamt = i_b[4:0];

    // both compares are formed once and shared by slt and sltu
    assign lt_signed   = ($signed(i_a) < $signed(i_b));
    assign lt_unsigned = (i_a < i_b);

    always_comb begin
        o_result = '0;
        case (i_op)
            ALU_ADD: begin
                o_result = i_a + i_b;
            end
            ALU_SUB: begin
                o_result = i_a - i_b;
            end
            ALU_SLL: begin
                o_result = i_a << shamt;
            end
            ALU_SLT: begin
                o_result = word_t'(lt_signed);
            end
            ALU_SLTU: begin
                o_result = word_t'(lt_unsigned);
            end
            ALU_XOR: begin
                o_result = i_a ^ i_b;
            end
            ALU_SRL: begin
                o_result = i_a >> shamt;
            end
            ALU_SRA: begin
                // arithmetic shift keeps the sign bit of i_a
                o_result = word_t'($signed(i_a) >>> shamt);
            end
            ALU_OR: begin
                o_result = i_a | i_b;
            end
            ALU_AND: begin
                o_result = i_a & i_b;
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

endmodule

//--- logic/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_regfile (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  rv_isa_pkg::reg_addr_t i_rs1_addr,
    input  rv_isa_pkg::reg_addr_t i_rs2_addr,
    input  rv_isa_pkg::reg_addr_t i_rd_addr,
    input  logic                  i_rd_wen,
    input  rv_isa_pkg::word_t     i_rd_data,
    output rv_isa_pkg::word_t     o_rs1_data,
    output rv_isa_pkg::word_t     o_rs2_data
);
    import rv_isa_pkg::*;

    // x0 has no storage, only x1 and up are real registers
    word_t regs [1:`RV_REG_COUNT-1];

    // a read sees x0 as zero and picks up a write landing on the same edge
    function automatic word_t read_port(input reg_addr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (i_rd_wen && (addr == i_rd_addr)) begin
            value = i_rd_data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 1; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_wen && (i_rd_addr != '0)) begin
            regs[i_rd_addr] <= i_rd_data;
        end
    end

    always_comb begin
        o_rs1_data = read_port(i_rs1_addr);
        o_rs2_data = read_port(i_rs2_addr);
    end

    // x0 stays zero on both ports, also while a write to it is presented
    assert property (@(posedge i_clk) disable iff (i_rst)
        ((i_rs1_addr != '0) || (o_rs1_data == '0)) &&
        ((i_rs2_addr != '0) || (o_rs2_data == '0)));

endmodule

//--- logic/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
    input  rv_isa_pkg::inst_t      i_inst,
    output rv_isa_pkg::reg_addr_t  o_rs1_addr,
    output rv_isa_pkg::reg_addr_t  o_rs2_addr,
    output rv_isa_pkg::reg_addr_t  o_rd_addr,
    output rv_isa_pkg::word_t      o_imm,
    output rv_pipe_pkg::alu_op_e   o_alu_op,
    output rv_pipe_pkg::op_a_sel_e o_op_a_sel,
    output rv_pipe_pkg::op_b_sel_e o_op_b_sel,
    output logic                   o_rd_wen,
    output logic                   o_halt
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    funct3_e funct3;
    word_t   imm_i;
    word_t   imm_u;
    logic    writes_rd;

    // funct3 together with the alternate bit 30 selects the ALU operation
    function automatic alu_op_e alu_from_funct3(input funct3_e f3, input logic alt);
        alu_op_e op;
        op = ALU_ADD;
        case (f3)
            F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            F3_AND:     op = ALU_AND;
            default:    op = ALU_ADD;
        endcase
        return op;
    endfunction

    assign funct3 = funct3_e'(i_inst[14:12]);

    // I-type keeps 12 sign-extended bits, U-type fills the upper 20
    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_u = {i_inst[31:12], 12'b0};

    assign o_rd_addr = i_inst[11:7];
    assign o_halt    = (i_inst == EBREAK_WORD);

    // a write to x0 is dropped here so later stages never see it
    assign o_rd_wen = writes_rd && (o_rd_addr != '0);

    always_comb begin
        o_rs1_addr = '0;
        o_rs2_addr = '0;
        o_imm      = '0;
        o_alu_op   = ALU_ADD;
        o_op_a_sel = OP_A_REG;
        o_op_b_sel = OP_B_REG;
        writes_rd  = 1'b0;
        case (i_inst[6:0])
            OP: begin
                o_rs1_addr = i_inst[19:15];
                o_rs2_addr = i_inst[24:20];
                o_alu_op   = alu_from_funct3(funct3, i_inst[30]);
                writes_rd  = 1'b1;
            end
            OP_IMM: begin
                o_rs1_addr = i_inst[19:15];
                o_imm      = imm_i;
                o_op_b_sel = OP_B_IMM;
                // there is no subtract immediate, bit 30 only matters for srai
                o_alu_op   = alu_from_funct3(funct3, i_inst[30] && (funct3 == F3_SRL_SRA));
                writes_rd  = 1'b1;
            end
            LUI: begin
                // rs1 stays at x0 so the ALU adds the immediate to zero
                o_imm      = imm_u;
                o_op_b_sel = OP_B_IMM;
                writes_rd  = 1'b1;
            end
            AUIPC: begin
                o_imm      = imm_u;
                o_op_a_sel = OP_A_PC;
                o_op_b_sel = OP_B_IMM;
                writes_rd  = 1'b1;
            end
            SYSTEM: begin
                // ebreak and friends write nothing, halt is flagged above
                writes_rd = 1'b0;
            end
            default: begin
                // unknown opcodes retire as no-ops
                writes_rd = 1'b0;
            end
        endcase
    end

    // an ebreak halts the core and must never write a register on its way out
    always_comb begin
        assert final (!(o_halt && o_rd_wen))
            else $error("decoder enabled a register write for ebreak");
    end

endmodule

//--- logic/rv_pipe_pkg.sv
package rv_pipe_pkg;

    // ========================================
    // execute stage controls
    // ========================================

    // every operation of the RV32I integer ALU
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // first ALU operand comes from rs1 or from the pc of the instruction
    // the pc path is only taken by auipc
    typedef enum logic {
        OP_A_REG,
        OP_A_PC
    } op_a_sel_e;

    // second ALU operand comes from rs2 or from the decoded immediate
    typedef enum logic {
        OP_B_REG,
        OP_B_IMM
    } op_b_sel_e;

endpackage

//--- logic/rv_isa_pkg.sv
package rv_isa_pkg;

`include "rv_settings.svh"

    // ========================================
    // architectural value types
    // ========================================

    // one data word or byte address
    typedef logic [`RV_XLEN-1:0] word_t;

    // instructions are always 32 bits wide, independent of xlen
    typedef logic [31:0] inst_t;

    // index into the integer register file
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

    // ========================================
    // encodings
    // ========================================

    // major opcodes that this core understands, bits 6:0 of the word
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        SYSTEM = 7'b1110011
    } opcode_e;

    // funct3 field of OP and OP_IMM, bit 30 picks sub and sra
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_e;

    // ebreak is SYSTEM with funct12 of one and all other fields zero
    localparam inst_t EBREAK_WORD = 32'h0010_0073;

endpackage

//--- include/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// ========================================
// core-wide sizing
// ========================================

// data path and address width of the integer core
`define RV_XLEN 32

// architectural integer registers, x0 included
`define RV_REG_COUNT 32
`define RV_REG_ADDR_W 5

// first fetch address once reset is released
`define RV_RESET_ADDR 32'h0000_0000

`endif
